//--- gb_bus.f
source/gb_bus_pkg.sv
source/gb_bus_decode.sv
source/gb_mem_block.sv
source/gb_int_ctrl.sv
source/gb_rdata_mux.sv
source/gb_bus.sv
tests/gb_bus_tb.sv

//--- tests/gb_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gb_bus_tb
    import gb_bus_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int WRAM_N     = 128;  // Random work RAM addresses
    localparam int IO_N       = 20;   // Random unmapped I/O addresses
    localparam int N_ACCESS   = 2 + 2 * 127 + 2 * WRAM_N + 40 + 2 * IO_N + 2 + 127 + 30;
    localparam int WD_NS      = (N_ACCESS + 300) * CLK_PERIOD;  // Idle cycles in the margin

    logic             clk = 1'b0;
    logic             rst = 1'b1;
    gb_req_s          req_in;
    logic [7:0]       ext_din;
    logic [INT_W-1:0] int_req;
    logic [INT_W-1:0] int_ack;
    logic [7:0]       rdata;
    logic             rdata_valid;
    logic [15:0]      ext_addr;
    logic [7:0]       ext_dout;
    logic             ext_rd;
    logic             ext_wr;
    logic             ext_cs;
    logic [INT_W-1:0] int_pending;
    logic             irq;

    ////////////////////////////////////////////////////////////
    // Reference model state
    ////////////////////////////////////////////////////////////

    logic [7:0]       mem_m [logic [15:0]];  // Shadow of both RAMs, keyed by CPU address
    logic [INT_W-1:0] ie_m;
    logic [INT_W-1:0] if_m;
    logic [7:0]       exp_next;   // Expected byte of the read in this cycle
    logic [7:0]       exp_rdata;  // Same, one cycle later
    logic             exp_valid;
    logic             ext_hit;    // Request goes to the cartridge bus
    int               err_cnt = 0;
    int               tests_ok = 0;
    int               tests_bad = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    gb_bus i_dut (.*);

    // Everything off the FF page and outside work RAM
    function automatic logic is_external(input logic [15:0] a);
        return !(a >= 16'hC000 && a <= 16'hDFFF) && (a[15:8] != 8'hFF);
    endfunction

    function automatic logic [7:0] expected_read(input logic [15:0] a);
        if (a == 16'hFFFF) return {3'b000, ie_m};
        if (a == 16'hFF0F) return {3'b000, if_m};
        if (a >= 16'hFF80) return mem_m[a];  // High RAM
        if (a >= 16'hFF00) return 8'hFF;     // Unmapped I/O
        if (a >= 16'hC000 && a <= 16'hDFFF) return mem_m[a];
        return ext_din;                      // Cartridge byte of the rd cycle
    endfunction

    assign ext_hit = is_external(req_in.addr.raw);

    // IE/IF rules, read pipeline of one
    always @(posedge clk) begin
        if (rst) begin
            ie_m      <= '0;
            if_m      <= '0;
            exp_valid <= 1'b0;
        end else begin
            exp_valid <= req_in.rd;
            if (req_in.wr && req_in.addr.raw == 16'hFFFF)
                ie_m <= req_in.wdata[INT_W-1:0];
            if (req_in.wr && req_in.addr.raw == 16'hFF0F)
                if_m <= req_in.wdata[INT_W-1:0] | int_req;  // Request kept
            else
                if_m <= (if_m & ~int_ack) | int_req;        // Request beats ack
        end
        exp_rdata <= exp_next;
    end

    ////////////////////////////////////////////////////////////
    // Checkers
    ////////////////////////////////////////////////////////////

    a_rdata: assert property (@(posedge clk) disable iff (rst)
        rdata_valid |-> rdata == exp_rdata)
    else begin
        $display("MISMATCH at %0t: rdata %h, expected %h", $time,
                 $sampled(rdata), $sampled(exp_rdata));
        err_cnt++;
    end

    a_valid: assert property (@(posedge clk) disable iff (rst) rdata_valid == exp_valid)
    else begin
        $display("At %0t rdata_valid was not high exactly one cycle after a read", $time);
        err_cnt++;
    end

    a_ext_strobes: assert property (@(posedge clk)
        ext_rd == (req_in.rd && ext_hit) && ext_wr == (req_in.wr && ext_hit)
        && ext_cs == ((req_in.rd || req_in.wr) && ext_hit))
    else begin
        $display("At %0t the external strobes did not follow the request", $time);
        err_cnt++;
    end

    a_ext_bus: assert property (@(posedge clk)
        ext_addr == req_in.addr.raw
        && ext_dout == ((req_in.wr && ext_hit) ? req_in.wdata : 8'h00))
    else begin
        $display("At %0t the external address or write data did not mirror the request", $time);
        err_cnt++;
    end

    a_pending: assert property (@(posedge clk) disable iff (rst)
        int_pending == (ie_m & if_m) && irq == |(ie_m & if_m))
    else begin
        $display("At %0t int_pending or irq did not match IE and IF", $time);
        err_cnt++;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic drive_cycle(input logic rd, input logic wr, input logic [15:0] a,
                               input logic [7:0] d, input logic [INT_W-1:0] rq,
                               input logic [INT_W-1:0] ak);
        @(posedge clk);
        #1;
        req_in.addr.raw = a;
        req_in.wdata    = d;
        req_in.rd       = rd;
        req_in.wr       = wr;
        int_req         = rq;
        int_ack         = ak;
        ext_din         = 8'($urandom);
        exp_next        = rd ? expected_read(a) : 8'h00;
    endtask

    task automatic write_at(input logic [15:0] a, input logic [7:0] d);
        drive_cycle(1'b0, 1'b1, a, d, '0, '0);
        if ((a >= 16'hFF80 && a != 16'hFFFF) || (a >= 16'hC000 && a <= 16'hDFFF))
            mem_m[a] = d;  // RAM targets only
    endtask

    task automatic read_at(input logic [15:0] a);
        drive_cycle(1'b1, 1'b0, a, 8'($urandom), '0, '0);
    endtask

    task automatic end_test(input string name, input int base);
        repeat (3) drive_cycle(1'b0, 1'b0, 16'h0000, 8'h00, '0, '0);  // Drain last read
        if (err_cnt == base) begin
            tests_ok++;
            $display("Test %s done, no errors", name);
        end else begin
            tests_bad++;
            $display("Test %s done, %0d errors", name, err_cnt - base);
        end
    endtask

    initial begin
        #(WD_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WD_NS);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int          base;
        logic [15:0] a;
        logic [15:0] addrs [$];
        logic [15:0] ext_list [10] = '{16'h0000, 16'h3FFF, 16'h7FFF, 16'h8000, 16'h9FFF,
                                       16'hA000, 16'hBFFF, 16'hE000, 16'hFE00, 16'hFE9F};
        void'($urandom(32'h188dcd1e));
        req_in   = '0;
        ext_din  = '0;
        int_req  = '0;
        int_ack  = '0;
        exp_next = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        base = err_cnt;  // Reset state
        assert (!rdata_valid && !irq && !ext_rd && !ext_wr && !ext_cs)
        else begin
            $display("Outputs were not idle after reset");
            err_cnt++;
        end
        read_at(16'hFFFF);
        read_at(16'hFF0F);
        end_test("reset", base);

        base = err_cnt;  // High RAM, reads back to back
        for (int i = 16'hFF80; i <= 16'hFFFE; i++)
            write_at(16'(i), 8'($urandom));
        for (int i = 16'hFF80; i <= 16'hFFFE; i++)
            read_at(16'(i));
        end_test("hram", base);

        base = err_cnt;
        for (int i = 0; i < WRAM_N; i++) begin
            a = 16'hC000 + 16'($urandom % 32'h2000);
            addrs.push_back(a);
            write_at(a, 8'($urandom));
        end
        foreach (addrs[i])
            read_at(addrs[i]);
        end_test("wram", base);

        base = err_cnt;
        write_at(16'hFFFF, 8'hEB);  // Upper bits dropped
        read_at(16'hFFFF);
        write_at(16'hFF0F, 8'hF4);
        read_at(16'hFF0F);
        write_at(16'hFF0F, 8'h00);
        write_at(16'hFFFF, 8'h1F);
        for (int i = 0; i < INT_W; i++) begin
            drive_cycle(1'b0, 1'b0, 16'h0000, 8'h00, INT_W'(1) << i, '0);  // Set
            read_at(16'hFF0F);
            drive_cycle(1'b0, 1'b0, 16'h0000, 8'h00, '0, INT_W'(1) << i);  // Clear
            read_at(16'hFF0F);
        end
        drive_cycle(1'b0, 1'b0, 16'h0000, 8'h00, 5'b00110, '0);
        drive_cycle(1'b0, 1'b0, 16'h0000, 8'h00, 5'b00010, 5'b00110);
        read_at(16'hFF0F);
        drive_cycle(1'b0, 1'b1, 16'hFF0F, 8'h01, 5'b01000, '0);  // Write plus request
        read_at(16'hFF0F);
        write_at(16'hFFFF, 8'h00);
        end_test("interrupts", base);

        base = err_cnt;
        for (int i = 0; i < IO_N; i++) begin
            a = 16'hFF00 + 16'($urandom % 128);
            if (a == 16'hFF0F)
                a = 16'hFF10;
            write_at(a, 8'($urandom));
            read_at(a);
        end
        read_at(16'hFF00);
        read_at(16'hFF7F);
        for (int i = 16'hFF80; i <= 16'hFFFE; i++)
            read_at(16'(i));  // High RAM untouched by the I/O writes
        end_test("unmapped", base);

        base = err_cnt;  // Cartridge and PPU windows
        foreach (ext_list[i]) begin
            write_at(ext_list[i], 8'($urandom));
            read_at(ext_list[i]);
        end
        write_at(16'hFF80, 8'hA5);  // Internal write, ext_dout stays 00
        read_at(16'h0000 + 16'($urandom % 32'h8000));
        end_test("external", base);

        $display("Tests passed %0d, failed %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/gb_bus.sv
`timescale 1ns/1ps
`default_nettype none

module gb_bus
    import gb_bus_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire gb_req_s     req_in,
    input  wire [7:0]        ext_din,
    input  wire [INT_W-1:0]  int_req,
    input  wire [INT_W-1:0]  int_ack,
    output logic [7:0]       rdata,
    output logic             rdata_valid,
    output logic [15:0]      ext_addr,
    output logic [7:0]       ext_dout,
    output logic             ext_rd,
    output logic             ext_wr,
    output logic             ext_cs,
    output logic [INT_W-1:0] int_pending,
    output logic             irq
);

    gb_sel_s          sel;
    logic [7:0]       hram_rdata;
    logic [7:0]       wram_rdata;
    logic [INT_W-1:0] ie_q;
    logic [INT_W-1:0] if_q;

    ////////////////////////////////////////////////////////////
    // Decode and internal targets
    ////////////////////////////////////////////////////////////

    gb_bus_decode i_decode (
        .clk    (clk),
        .rst    (rst),
        .req_in (req_in),
        .sel    (sel)
    );

    gb_mem_block i_mem (
        .clk        (clk),
        .addr       (req_in.addr),
        .wdata      (req_in.wdata),
        .hram_we    (sel.hram_we),
        .wram_we    (sel.wram_we),
        .hram_rdata (hram_rdata),
        .wram_rdata (wram_rdata)
    );

    gb_int_ctrl i_int (
        .clk         (clk),
        .rst         (rst),
        .wdata       (req_in.wdata[INT_W-1:0]),  // Upper bits not stored
        .ie_we       (sel.ie_we),
        .if_we       (sel.if_we),
        .int_req     (int_req),
        .int_ack     (int_ack),
        .ie_q        (ie_q),
        .if_q        (if_q),
        .int_pending (int_pending),
        .irq         (irq)
    );

    gb_rdata_mux i_rmux (
        .clk         (clk),
        .rst         (rst),
        .region      (sel.region),
        .rd          (sel.rd),
        .hram_rdata  (hram_rdata),
        .wram_rdata  (wram_rdata),
        .ie_q        (ie_q),
        .if_q        (if_q),
        .ext_din     (ext_din),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    ////////////////////////////////////////////////////////////
    // Cartridge bus, same cycle as the request
    ////////////////////////////////////////////////////////////

    assign ext_addr = req_in.addr.raw;                      // Always exposed
    assign ext_dout = sel.ext_wr ? req_in.wdata : 8'h00;    // Masked for internal writes
    assign ext_rd   = sel.ext_rd;
    assign ext_wr   = sel.ext_wr;
    assign ext_cs   = sel.ext_rd | sel.ext_wr;

endmodule

`default_nettype wire

//--- source/gb_rdata_mux.sv
`timescale 1ns/1ps
`default_nettype none

module gb_rdata_mux
    import gb_bus_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire gb_region_e  region,
    input  wire              rd,
    input  wire [7:0]        hram_rdata,  // Already registered in the RAM block
    input  wire [7:0]        wram_rdata,
    input  wire [INT_W-1:0]  ie_q,
    input  wire [INT_W-1:0]  if_q,
    input  wire [7:0]        ext_din,
    output logic [7:0]       rdata,
    output logic             rdata_valid
);

    gb_region_e       region_q;  // Region of the read in flight
    logic [INT_W-1:0] ie_s;
    logic [INT_W-1:0] if_s;
    logic [7:0]       ext_s;     // Cartridge byte seen in the rd cycle

    ////////////////////////////////////////////////////////////
    // Capture at the end of the rd cycle
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= rd;
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            region_q <= region;
            ie_s     <= ie_q;
            if_s     <= if_q;
            ext_s    <= ext_din;
        end
    end

    // Source select, upper IE/IF bits read zero
    always_comb begin
        case (region_q)
            REG_HRAM: rdata = hram_rdata;
            REG_WRAM: rdata = wram_rdata;
            REG_IE:   rdata = {{(8-INT_W){1'b0}}, ie_s};
            REG_IF:   rdata = {{(8-INT_W){1'b0}}, if_s};
            REG_EXT:  rdata = ext_s;
            default:  rdata = 8'hFF;  // Unmapped I/O
        endcase
    end

    // Fixed latency of one, also for back to back reads
    a_valid_after_rd: assert property (
        @(posedge clk) disable iff (rst)
        rdata_valid |-> $past(rd) && !$past(rst)
    ) else $error("rdata_valid without a read in the previous cycle");

endmodule

`default_nettype wire

//--- source/gb_int_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module gb_int_ctrl
    import gb_bus_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire [INT_W-1:0]  wdata,     // Low bits of the CPU byte
    input  wire              ie_we,
    input  wire              if_we,
    input  wire [INT_W-1:0]  int_req,   // One clk pulses from peripherals
    input  wire [INT_W-1:0]  int_ack,   // One clk pulses from the CPU
    output logic [INT_W-1:0] ie_q,
    output logic [INT_W-1:0] if_q,
    output logic [INT_W-1:0] int_pending,
    output logic             irq
);

    ////////////////////////////////////////////////////////////
    // IE register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ie_q <= '0;
        end else if (ie_we) begin
            ie_q <= wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // IF register
    ////////////////////////////////////////////////////////////

    logic [INT_W-1:0] if_next;

    // Write beats ack, a new request beats both
    always_comb begin
        if (if_we) begin
            if_next = wdata | int_req;
        end else begin
            if_next = (if_q & ~int_ack) | int_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            if_q <= '0;
        end else begin
            if_q <= if_next;
        end
    end

    // Pending view for the CPU
    assign int_pending = ie_q & if_q;
    assign irq         = |int_pending;

    // irq only rises after a request or a register write, and only with IE set
    a_irq_rise: assert property (
        @(posedge clk) disable iff (rst)
        $rose(irq) |-> (ie_q != '0) &&
                       (($past(int_req) != '0) || $past(ie_we) || $past(if_we))
    ) else $error("irq rose without IE or without a cause");

endmodule

`default_nettype wire

//--- source/gb_mem_block.sv
`timescale 1ns/1ps
`default_nettype none

module gb_mem_block
    import gb_bus_pkg::*;
(
    input  wire             clk,
    input  wire gb_addr_u   addr,
    input  wire [7:0]       wdata,
    input  wire             hram_we,
    input  wire             wram_we,
    output logic [7:0]      hram_rdata,  // Valid one edge after addr
    output logic [7:0]      wram_rdata   // Same
);

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    localparam int HRAM_WORDS = 1 << HRAM_AW;  // 128
    localparam int WRAM_WORDS = 1 << WRAM_AW;  // 8192

    logic [7:0] hram [HRAM_WORDS];
    logic [7:0] wram [WRAM_WORDS];

    logic [HRAM_AW-1:0] hram_idx;
    logic [WRAM_AW-1:0] wram_idx;

    // Low address bits index each array directly
    assign hram_idx = addr.raw[HRAM_AW-1:0];  // FF80 maps to word 0
    assign wram_idx = addr.raw[WRAM_AW-1:0];  // C000 maps to word 0

    ////////////////////////////////////////////////////////////
    // High RAM port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (hram_we) begin
            hram[hram_idx] <= wdata;
        end else begin
            hram_rdata <= hram[hram_idx];  // Free-running read
        end
    end

    ////////////////////////////////////////////////////////////
    // Work RAM port
    ////////////////////////////////////////////////////////////

    // Single port, write has priority over the read register
    always_ff @(posedge clk) begin
        if (wram_we) begin
            wram[wram_idx] <= wdata;
        end else begin
            wram_rdata <= wram[wram_idx];
        end
    end

endmodule

`default_nettype wire

//--- source/gb_bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module gb_bus_decode
    import gb_bus_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire gb_req_s    req_in,
    output gb_sel_s         sel
);

    ////////////////////////////////////////////////////////////
    // Region match
    ////////////////////////////////////////////////////////////

    logic       ff_page;   // FF00..FFFF
    logic       is_ie;
    logic       is_if;
    logic       is_hram;
    logic       is_io;
    logic       is_wram;
    gb_region_e region;

    assign ff_page = (req_in.addr.pg.page == IO_BASE[15:8]);

    // Single registers sit on the FF page
    assign is_ie   = ff_page && (req_in.addr.pg.offset == ADDR_IE[7:0]);
    assign is_if   = ff_page && (req_in.addr.pg.offset == ADDR_IF[7:0]);
    assign is_hram = ff_page && (req_in.addr.pg.offset >= HRAM_BASE[7:0]);  // FFFF taken by IE

    // Range checks on the flat view
    assign is_io   = (req_in.addr.raw >= IO_BASE) && (req_in.addr.raw <= IO_LAST);
    assign is_wram = (req_in.addr.raw >= WRAM_BASE) && (req_in.addr.raw <= WRAM_LAST);

    // Fixed priority, PPU windows fall through to the cartridge bus
    always_comb begin
        if (is_ie) begin
            region = REG_IE;
        end else if (is_if) begin
            region = REG_IF;
        end else if (is_hram) begin
            region = REG_HRAM;
        end else if (is_io) begin
            region = REG_UNMAPPED;  // Reads FF, writes dropped
        end else if (is_wram) begin
            region = REG_WRAM;
        end else begin
            region = REG_EXT;
        end
    end

    ////////////////////////////////////////////////////////////
    // Strobes
    ////////////////////////////////////////////////////////////

    always_comb begin
        sel.region  = region;
        sel.hram_we = req_in.wr && (region == REG_HRAM);
        sel.wram_we = req_in.wr && (region == REG_WRAM);
        sel.ie_we   = req_in.wr && (region == REG_IE);
        sel.if_we   = req_in.wr && (region == REG_IF);
        sel.ext_rd  = req_in.rd && (region == REG_EXT);
        sel.ext_wr  = req_in.wr && (region == REG_EXT);
        sel.rd      = req_in.rd;  // Every region answers a read
    end

    // CPU side never reads and writes together
    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(req_in.rd && req_in.wr)
    ) else $error("rd and wr both high at %h", req_in.addr.raw);

    // A write lands in at most one target
    a_one_we: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({sel.hram_we, sel.wram_we, sel.ie_we, sel.if_we, sel.ext_wr})
    ) else $error("More than one write strobe at %h", req_in.addr.raw);

endmodule

`default_nettype wire

//--- source/gb_bus_pkg.sv
`default_nettype none

package gb_bus_pkg;

    ////////////////////////////////////////////////////////////
    // Memory map
    ////////////////////////////////////////////////////////////

    localparam logic [15:0] HRAM_BASE = 16'hFF80;  // High RAM, up to FFFE
    localparam logic [15:0] WRAM_BASE = 16'hC000;
    localparam logic [15:0] WRAM_LAST = 16'hDFFF;
    localparam logic [15:0] IO_BASE   = 16'hFF00;  // Also gives the FF page
    localparam logic [15:0] IO_LAST   = 16'hFF7F;
    localparam logic [15:0] ADDR_IE   = 16'hFFFF;  // Interrupt enable
    localparam logic [15:0] ADDR_IF   = 16'hFF0F;  // Interrupt flags

    localparam int INT_W   = 5;   // VBlank, LCDC, timer, serial, joypad
    localparam int HRAM_AW = 7;   // 128 bytes
    localparam int WRAM_AW = 13;  // 8 KiB

    ////////////////////////////////////////////////////////////
    // Bus types
    ////////////////////////////////////////////////////////////

    // Page/offset view of a CPU address
    typedef struct packed {
        logic [7:0] page;    // Upper byte
        logic [7:0] offset;  // Lower byte
    } gb_page_s;

    // Same 16 bits, decoded flat or by page
    typedef union packed {
        logic [15:0] raw;
        gb_page_s    pg;
    } gb_addr_u;

    // CPU request, 26 bits
    typedef struct packed {
        gb_addr_u   addr;
        logic [7:0] wdata;
        logic       rd;   // One clk per read
        logic       wr;   // One clk per write
    } gb_req_s;

    // Decoded target of an access
    typedef enum logic [2:0] {
        REG_HRAM     = 3'd0,
        REG_WRAM     = 3'd1,
        REG_IE       = 3'd2,
        REG_IF       = 3'd3,
        REG_UNMAPPED = 3'd4,
        REG_EXT      = 3'd5
    } gb_region_e;

    // Decoder output, strobes already gated by region
    typedef struct packed {
        gb_region_e region;
        logic       hram_we;
        logic       wram_we;
        logic       ie_we;
        logic       if_we;
        logic       ext_rd;
        logic       ext_wr;
        logic       rd;       // Any read, all regions
    } gb_sel_s;

endpackage

`default_nettype wire
